/* tb.f */
ahb3lite_pkg.sv
ahb_bus_if.sv
ahb_burst_tracker.sv
ahb_protocol_monitor.sv
ahb_sram_slave.sv
ahb_subsystem_top.sv
ahb_subsystem_checker.sv
tb_ahb_subsystem.sv

/* run.sh */
#!/bin/sh
# Build and run the AHB3-Lite subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ahb_subsystem -f tb.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ahb_subsystem 2>&1); then
  echo "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -q "Result: PASSED"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

/* tb_ahb_subsystem.sv */
////////////////////////////////////////
// AHB3-Lite subsystem testbench
// Table-driven bus master, checks read
// data, timing and violation reports
////////////////////////////////////////

module tb_ahb_subsystem;
  import ahb3lite_pkg::*;

  // One bus cycle of the master, with what the DUT must show
  typedef struct packed {
    htrans_t               trans;
    hburst_t               burst;
    hsize_t                size;
    logic [addr_width-1:0] addr;
    logic                  write;
    logic [data_width-1:0] wdata;
    logic [1:0]            ws;
    violation_t            code;
    logic                  force_adv;
    logic                  err_dp;
    logic                  chk_rd;
    logic [data_width-1:0] exp_rd;
    logic [3:0]            cyc;
  } row_t;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  hsel;
  logic [addr_width-1:0] haddr;
  logic [data_width-1:0] hwdata;
  logic                  hwrite;
  hsize_t                hsize;
  hburst_t               hburst;
  htrans_t               htrans;
  logic [1:0]            wait_states;
  logic [data_width-1:0] hrdata;
  logic                  hready;
  hresp_t                hresp;
  logic                  violation_valid;
  violation_t            violation_code;
  logic [7:0]            violation_count;

  row_t        rows[$];
  string       names[$];
  bit          table_ready;

  // Reference memory and open data phase while the table is built
  logic [data_width-1:0] model [mem_words];
  bit                    model_ok [mem_words];
  logic [data_width-1:0] cur_wdata;
  logic [3:0]            remain;
  bit                    cur_err;
  bit                    pend_chk;
  logic [data_width-1:0] pend_rd;

  ahb_subsystem_top uut (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .hsel            (hsel),
    .haddr           (haddr),
    .hwdata          (hwdata),
    .hwrite          (hwrite),
    .hsize           (hsize),
    .hburst          (hburst),
    .htrans          (htrans),
    .wait_states     (wait_states),
    .hrdata          (hrdata),
    .hready          (hready),
    .hresp           (hresp),
    .violation_valid (violation_valid),
    .violation_code  (violation_code),
    .violation_count (violation_count)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(string test, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("mismatch %s expected %h actual %h", test, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  task automatic add_row(string name, htrans_t trans, hburst_t burst, hsize_t size,
                         logic [31:0] addr, bit write, logic [1:0] ws, violation_t code,
                         bit force_adv);
    row_t r;
    bit   xfer;
    bit   oob;
    int   word;
    xfer = (trans == nonseq || trans == seq);
    oob  = xfer && (addr >= 32'(mem_words * 4));
    word = int'((addr >> 2) % mem_words);
    r = '0;
    r.trans     = trans;
    r.burst     = burst;
    r.size      = size;
    r.addr      = addr;
    r.write     = write;
    r.ws        = ws;
    r.code      = code;
    r.force_adv = force_adv;
    // Row rides on the data phase of the last accepted transfer
    r.wdata  = cur_wdata;
    r.err_dp = cur_err;
    r.cyc    = force_adv ? 4'd1 : remain;
    r.chk_rd = force_adv ? 1'b0 : pend_chk;
    r.exp_rd = pend_rd;
    if (force_adv)
      remain = remain - 4'd1;
    else
    begin
      // Length of the data phase this row opens
      remain   = !xfer ? 4'd1 : oob ? 4'd2 : 4'd1 + 4'(ws);
      cur_err  = oob;
      pend_chk = xfer && !oob && !write && model_ok[word];
      pend_rd  = model[word];
      if (xfer && write && !oob)
      begin
        cur_wdata      = $urandom();
        model[word]    = cur_wdata;
        model_ok[word] = 1'b1;
      end
    end
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Word burst stepping by 4 and wrapping at beats x 4 bytes
  task automatic add_burst(string name, hburst_t burst, logic [31:0] start, bit write,
                           logic [1:0] ws, int beats);
    logic [31:0] addr;
    logic [31:0] span;
    htrans_t     kind;
    addr = start;
    span = 32'(beats * 4);
    for (int k = 0; k < beats; k++)
    begin
      if (k == 0)
        kind = nonseq;
      else
        kind = seq;
      add_row($sformatf("%s_%0d", name, k), kind, burst, size_word, addr, write, ws,
              none, 1'b0);
      if (burst == wrap4 || burst == wrap8 || burst == wrap16)
        addr = (addr & ~(span - 1)) | ((addr + 32'd4) & (span - 1));
      else
        addr = addr + 32'd4;
    end
  endtask

  task automatic build_table();
    cur_wdata = '0;
    remain    = 4'd1;
    cur_err   = 1'b0;
    pend_chk  = 1'b0;
    pend_rd   = '0;
    for (int i = 0; i < mem_words; i++)
      model_ok[i] = 1'b0;
    // Single transfers over every wait-state setting
    add_row("wr_ws0", nonseq, single, size_word, 32'h000, 1'b1, 2'd0, none, 1'b0);
    add_row("wr_ws1", nonseq, single, size_word, 32'h004, 1'b1, 2'd1, none, 1'b0);
    add_row("wr_ws2", nonseq, single, size_word, 32'h008, 1'b1, 2'd2, none, 1'b0);
    add_row("wr_ws3", nonseq, single, size_word, 32'h00c, 1'b1, 2'd3, none, 1'b0);
    add_row("rd_ws0", nonseq, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    add_row("rd_ws1", nonseq, single, size_word, 32'h004, 1'b0, 2'd1, none, 1'b0);
    add_row("rd_ws2", nonseq, single, size_word, 32'h008, 1'b0, 2'd2, none, 1'b0);
    add_row("rd_ws3", nonseq, single, size_word, 32'h00c, 1'b0, 2'd3, none, 1'b0);
    add_row("idle_single", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    // Legal bursts where WRAP8 from 0x078 wraps back to 0x060
    add_burst("incr4_wr", incr4, 32'h040, 1'b1, 2'd1, 4);
    add_burst("incr4_rd", incr4, 32'h040, 1'b0, 2'd2, 4);
    add_burst("wrap8_wr", wrap8, 32'h078, 1'b1, 2'd1, 8);
    add_burst("wrap8_rd", wrap8, 32'h078, 1'b0, 2'd2, 8);
    add_row("idle_burst", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    // Master protocol errors
    add_row("seq_alone", seq, single, size_word, 32'h010, 1'b0, 2'd0, seq_outside_burst, 1'b0);
    add_row("idle_a", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    add_row("skip_0", nonseq, incr4, size_word, 32'h100, 1'b0, 2'd0, none, 1'b0);
    add_row("skip_1", seq, incr4, size_word, 32'h108, 1'b0, 2'd0, burst_addr, 1'b0);
    add_row("skip_2", seq, incr4, size_word, 32'h10c, 1'b0, 2'd0, none, 1'b0);
    add_row("skip_3", seq, incr4, size_word, 32'h110, 1'b0, 2'd0, none, 1'b0);
    add_row("cut_0", nonseq, incr4, size_word, 32'h120, 1'b0, 2'd0, none, 1'b0);
    add_row("cut_1", seq, incr4, size_word, 32'h124, 1'b0, 2'd0, none, 1'b0);
    add_row("cut_idle", idle, incr4, size_word, 32'h000, 1'b0, 2'd0, burst_early_end, 1'b0);
    add_row("wait_wr", nonseq, single, size_word, 32'h020, 1'b1, 2'd2, none, 1'b0);
    // Misbehaving master moves HADDR in the middle of the wait states
    add_row("wait_rd_a", nonseq, single, size_word, 32'h024, 1'b0, 2'd0, none, 1'b1);
    add_row("wait_rd_b", nonseq, single, size_word, 32'h028, 1'b0, 2'd0, unstable_wait, 1'b0);
    add_row("dword", nonseq, single, size_dword, 32'h030, 1'b0, 2'd0, hsize_range, 1'b0);
    // Out of range access followed by a normal one
    add_row("idle_b", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    add_row("oob_rd", nonseq, single, size_word, 32'h400, 1'b0, 2'd0, none, 1'b0);
    add_row("oob_idle", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
    add_row("post_wr", nonseq, single, size_word, 32'h3fc, 1'b1, 2'd1, none, 1'b0);
    add_row("post_rd", nonseq, single, size_word, 32'h3fc, 1'b0, 2'd0, none, 1'b0);
    add_row("idle_end", idle, single, size_word, 32'h000, 1'b0, 2'd0, none, 1'b0);
  endtask

  task automatic apply_row(row_t r);
    hsel        = 1'b1;
    htrans      = r.trans;
    hburst      = r.burst;
    hsize       = r.size;
    haddr       = r.addr;
    hwrite      = r.write;
    hwdata      = r.wdata;
    wait_states = r.ws;
  endtask

  ////////////////////////////////////////
  // Run
  ////////////////////////////////////////

  initial
  begin
    int         idx;
    int         held;
    int         exp_count;
    bit         ready_now;
    violation_t exp_code;
    hresp_t     exp_resp;
    void'($urandom(32'h7d24));
    HRESETn     = 1'b0;
    hsel        = 1'b0;
    haddr       = '0;
    hwdata      = '0;
    hwrite      = 1'b0;
    hsize       = size_word;
    hburst      = single;
    htrans      = idle;
    wait_states = 2'd0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn   = 1'b1;
    idx       = 0;
    held      = 0;
    exp_count = 0;
    while (idx < rows.size())
    begin
      // hready and hrdata only change at a rising edge
      ready_now = hready;
      if (ready_now && rows[idx].chk_rd)
        check_value({names[idx], " hrdata"}, rows[idx].exp_rd, hrdata);
      exp_resp = rows[idx].err_dp ? error : okay;
      check_value({names[idx], " hresp"}, 32'(exp_resp), 32'(hresp));
      apply_row(rows[idx]);
      @(negedge HCLK);
      // Violation belongs to the first edge that samples the row
      if (held == 0)
        exp_code = rows[idx].code;
      else
        exp_code = none;
      check_value({names[idx], " code"}, 32'(exp_code), 32'(violation_code));
      check_value({names[idx], " valid"}, {31'd0, exp_code != none}, {31'd0, violation_valid});
      held = held + 1;
      if (ready_now || rows[idx].force_adv)
      begin
        check_value({names[idx], " cycles"}, 32'(rows[idx].cyc), 32'(held));
        if (rows[idx].code != none)
          exp_count = exp_count + 1;
        idx  = idx + 1;
        held = 0;
      end
    end
    check_value("violation_count", 32'(exp_count), 32'(violation_count));
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog allows eight cycles per table row
  initial
  begin
    wait (table_ready);
    repeat (rows.size() * 8) @(posedge HCLK);
    $display("Timeout: the stimulus table did not finish in time");
    abort_run();
  end

endmodule

/* ahb_subsystem_checker.sv */
////////////////////////////////////////
// AHB slave response checker
// Bound assertions on the IDLE/BUSY and
// two-cycle ERROR rules of the slave
////////////////////////////////////////

module ahb_subsystem_checker (
  input logic                  HCLK,
  input logic                  HRESETn,
  input ahb3lite_pkg::htrans_t htrans,
  input logic                  hready,
  input ahb3lite_pkg::hresp_t  hresp
);
  import ahb3lite_pkg::*;

  // IDLE or BUSY accepted, its data phase is zero-wait OKAY
  idle_busy_ready: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (hready && (htrans == idle || htrans == busy)) |=> (hready && hresp == okay)
  ) else $error("slave stalled or failed an IDLE or BUSY data phase");

  // First ERROR cycle is always followed by the second
  error_pair: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (!hready && hresp == error) |=> (hready && hresp == error)
  ) else $error("ERROR with hready low was not followed by ERROR with hready high");

  // Second ERROR cycle never appears on its own
  error_second: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (hready && hresp == error) |-> $past(!hready && hresp == error)
  ) else $error("ERROR with hready high came without the low cycle before it");

endmodule

// Checker sits inside every memory slave
bind ahb_sram_slave ahb_subsystem_checker u_checker (
  .HCLK    (HCLK),
  .HRESETn (HRESETn),
  .htrans  (bus.htrans),
  .hready  (bus.hready),
  .hresp   (bus.hresp)
);

/* ahb_subsystem_top.sv */
////////////////////////////////////////
// AHB3-Lite subsystem top level
// Memory slave with its protocol monitor
// on one bus driven from the ports
////////////////////////////////////////

module ahb_subsystem_top (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                hsel,
  input  logic [ahb3lite_pkg::addr_width-1:0] haddr,
  input  logic [ahb3lite_pkg::data_width-1:0] hwdata,
  input  logic                                hwrite,
  input  ahb3lite_pkg::hsize_t                hsize,
  input  ahb3lite_pkg::hburst_t               hburst,
  input  ahb3lite_pkg::htrans_t               htrans,
  input  logic [1:0]                          wait_states,
  output logic [ahb3lite_pkg::data_width-1:0] hrdata,
  output logic                                hready,
  output ahb3lite_pkg::hresp_t                hresp,
  output logic                                violation_valid,
  output ahb3lite_pkg::violation_t            violation_code,
  output logic [7:0]                          violation_count
);

  ahb_bus_if bus (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  // Master side from the ports
  assign bus.hsel   = hsel;
  assign bus.haddr  = haddr;
  assign bus.hwdata = hwdata;
  assign bus.hwrite = hwrite;
  assign bus.hsize  = hsize;
  assign bus.hburst = hburst;
  assign bus.htrans = htrans;

  // Slave side back out
  assign hrdata = bus.hrdata;
  assign hready = bus.hready;
  assign hresp  = bus.hresp;

  ahb_sram_slave u_slave (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .bus         (bus),
    .wait_states (wait_states)
  );

  ahb_protocol_monitor u_monitor (
    .HCLK            (HCLK),
    .HRESETn         (HRESETn),
    .bus             (bus),
    .violation_valid (violation_valid),
    .violation_code  (violation_code),
    .violation_count (violation_count)
  );

endmodule

/* ahb_sram_slave.sv */
////////////////////////////////////////
// AHB3-Lite memory slave
// 256 x 32 memory with programmable wait
// states, ERROR above the memory range
////////////////////////////////////////

module ahb_sram_slave (
  input  logic       HCLK,
  input  logic       HRESETn,
  ahb_bus_if.slave   bus,
  input  logic [1:0] wait_states
);
  import ahb3lite_pkg::*;

  // Data phase FSM
  typedef enum logic [1:0] {
    st_ready,
    st_data,
    st_err1,
    st_err2
  } state_t;

  logic [data_width-1:0]        mem [mem_words];
  state_t                       state;
  logic [1:0]                   wait_cnt;
  logic [$clog2(mem_words)-1:0] dp_addr;
  logic                         dp_write;
  logic                         accept;
  logic                         in_range;

  // Address phase completes here
  assign accept = bus.hready && bus.hsel &&
                  (bus.htrans == nonseq || bus.htrans == seq);
  assign in_range = (bus.haddr < addr_width'(mem_words * 4));

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_comb
  begin
    case (state)
      st_data: bus.hready = (wait_cnt == 2'd0);
      st_err1: bus.hready = 1'b0;
      default: bus.hready = 1'b1;
    endcase
    bus.hresp = (state == st_err1 || state == st_err2) ? error : okay;
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state    <= st_ready;
      wait_cnt <= 2'd0;
    end
    else if (state == st_data && wait_cnt != 2'd0)
    begin
      // Wait state, hready held low
      wait_cnt <= wait_cnt - 2'd1;
    end
    else if (state == st_err1)
    begin
      state <= st_err2;
    end
    else if (accept)
    begin
      // No wait states ahead of an ERROR
      if (in_range)
      begin
        state    <= st_data;
        wait_cnt <= wait_states;
      end
      else
      begin
        state <= st_err1;
      end
    end
    else
    begin
      state <= st_ready;
    end
  end

  ////////////////////////////////////////
  // Memory
  ////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      dp_addr  <= bus.haddr[$clog2(mem_words)+1:2];
      dp_write <= bus.hwrite;
    end
    // Write lands on the last edge of the data phase
    if (state == st_data && wait_cnt == 2'd0 && dp_write)
      mem[dp_addr] <= bus.hwdata;
  end

  // Valid for a read when hready rises
  assign bus.hrdata = mem[dp_addr];

endmodule

/* ahb_protocol_monitor.sv */
////////////////////////////////////////
// AHB3-Lite protocol monitor
// Checks master and slave behaviour and
// reports the highest-priority violation
// as a one-cycle strobe with a count
////////////////////////////////////////

module ahb_protocol_monitor (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  ahb_bus_if.monitor               bus,
  output logic                     violation_valid,
  output ahb3lite_pkg::violation_t violation_code,
  output logic [7:0]               violation_count
);
  import ahb3lite_pkg::*;

  // Burst context
  logic                  in_burst;
  logic                  last_beat;
  logic [addr_width-1:0] expected_addr;

  // Bus values at the previous edge
  htrans_t               prev_htrans;
  logic                  prev_hready;
  hresp_t                prev_hresp;
  logic [addr_width-1:0] prev_haddr;
  hsize_t                prev_hsize;
  hburst_t               prev_hburst;
  logic                  prev_hwrite;
  logic [data_width-1:0] prev_hwdata;

  // Rule results
  logic       active;
  logic       in_wait;
  logic       rule_seq;
  logic       rule_busy;
  logic       rule_early;
  logic       rule_wait;
  logic       rule_stable;
  logic       rule_addr;
  logic       rule_size;
  logic       rule_idle;
  logic       rule_err;
  violation_t code;

  ahb_burst_tracker u_tracker (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .bus           (bus),
    .in_burst      (in_burst),
    .last_beat     (last_beat),
    .expected_addr (expected_addr)
  );

  ////////////////////////////////////////
  // Previous cycle
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prev_htrans <= idle;
      prev_hready <= 1'b1;
      prev_hresp  <= okay;
    end
    else
    begin
      prev_htrans <= bus.htrans;
      prev_hready <= bus.hready;
      prev_hresp  <= bus.hresp;
    end
  end

  always_ff @(posedge HCLK)
  begin
    prev_haddr  <= bus.haddr;
    prev_hsize  <= bus.hsize;
    prev_hburst <= bus.hburst;
    prev_hwrite <= bus.hwrite;
    prev_hwdata <= bus.hwdata;
  end

  ////////////////////////////////////////
  // Rules
  ////////////////////////////////////////

  assign active = (bus.htrans == nonseq) || (bus.htrans == seq);

  // Wait state seen last edge, master may still cancel after ERROR
  assign in_wait = !prev_hready && (prev_hresp == okay);

  // Legality is judged once, at the edge that completes the address phase
  assign rule_seq   = bus.hready && (bus.htrans == seq) && !in_burst;
  assign rule_busy  = bus.hready && (bus.htrans == busy) && !in_burst;
  assign rule_early = bus.hready && (bus.hresp == okay) && in_burst && !last_beat &&
                      (bus.htrans == idle || bus.htrans == nonseq);

  // Master held everything through the wait state
  assign rule_wait = in_wait &&
                     (bus.htrans != prev_htrans || bus.haddr != prev_haddr ||
                      bus.hsize != prev_hsize || bus.hburst != prev_hburst ||
                      bus.hwrite != prev_hwrite || bus.hwdata != prev_hwdata);

  // Control fixed across the beats of one burst
  assign rule_stable = in_burst && (bus.htrans == seq || bus.htrans == busy) &&
                       (bus.hsize != prev_hsize || bus.hburst != prev_hburst ||
                        bus.hwrite != prev_hwrite);

  assign rule_addr = bus.hready && (bus.htrans == seq) && in_burst &&
                     (bus.haddr != expected_addr);
  assign rule_size = bus.hready && active && ((32'd8 << bus.hsize) > data_width);

  // IDLE and BUSY data phases are zero-wait OKAY
  assign rule_idle = prev_hready && (prev_htrans == idle || prev_htrans == busy) &&
                     (!bus.hready || bus.hresp != okay);

  // ERROR low phase and high phase always come as a pair
  assign rule_err = (bus.hready && bus.hresp == error &&
                     !(!prev_hready && prev_hresp == error)) ||
                    (!prev_hready && prev_hresp == error &&
                     !(bus.hready && bus.hresp == error));

  // Priority encoder, lowest code first
  always_comb
  begin
    if (rule_seq)
      code = seq_outside_burst;
    else if (rule_busy)
      code = busy_outside_burst;
    else if (rule_early)
      code = burst_early_end;
    else if (rule_wait)
      code = unstable_wait;
    else if (rule_stable)
      code = unstable_burst;
    else if (rule_addr)
      code = burst_addr;
    else if (rule_size)
      code = hsize_range;
    else if (rule_idle)
      code = slave_idle_resp;
    else if (rule_err)
      code = slave_error_seq;
    else
      code = none;
  end

  ////////////////////////////////////////
  // Report
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      violation_valid <= 1'b0;
      violation_code  <= none;
      violation_count <= 8'd0;
    end
    else
    begin
      violation_valid <= (code != none);
      violation_code  <= code;
      // Saturates at 255
      if (code != none && violation_count != 8'hff)
        violation_count <= violation_count + 8'd1;
    end
  end

endmodule

/* ahb_burst_tracker.sv */
////////////////////////////////////////
// AHB burst tracker
// Follows the open burst, its remaining
// beats and the next expected address
////////////////////////////////////////

module ahb_burst_tracker (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  ahb_bus_if.monitor                          bus,
  output logic                                in_burst,
  output logic                                last_beat,
  output logic [ahb3lite_pkg::addr_width-1:0] expected_addr
);
  import ahb3lite_pkg::*;

  // Burst context, captured at the address phase
  hburst_t               burst_q;
  hsize_t                size_q;
  logic [addr_width-1:0] addr_q;
  logic [3:0]            beats_left;

  // Address in size units
  logic [addr_width-1:0] unit_addr;
  logic [addr_width-1:0] next_unit;

  // SEQ beats that follow the NONSEQ of a fixed burst
  function automatic logic [3:0] burst_beats(hburst_t burst);
    case (burst)
      wrap4, incr4:   burst_beats = 4'd3;
      wrap8, incr8:   burst_beats = 4'd7;
      wrap16, incr16: burst_beats = 4'd15;
      default:        burst_beats = 4'd0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Burst state
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      in_burst   <= 1'b0;
      beats_left <= 4'd0;
    end
    else if (bus.hready)
    begin
      case (bus.htrans)
        idle:
        begin
          in_burst   <= 1'b0;
          beats_left <= 4'd0;
        end
        // Opens a new burst, also ends any open one
        nonseq:
        begin
          in_burst   <= (bus.hburst != single);
          beats_left <= burst_beats(bus.hburst);
        end
        seq:
        begin
          // Undefined length keeps the counter at zero
          if (in_burst && burst_q != incr)
          begin
            beats_left <= beats_left - 4'd1;
            // Final beat closes the burst
            if (beats_left == 4'd1)
              in_burst <= 1'b0;
          end
        end
        default:
        begin
          // BUSY is not a transfer
          beats_left <= beats_left;
        end
      endcase
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (bus.hready && bus.htrans == nonseq)
    begin
      burst_q <= bus.hburst;
      size_q  <= bus.hsize;
    end
    if (bus.hready && (bus.htrans == nonseq || bus.htrans == seq))
      addr_q <= bus.haddr;
  end

  // An undefined-length burst may stop after any beat
  assign last_beat = in_burst && (burst_q == incr);

  ////////////////////////////////////////
  // Next address
  ////////////////////////////////////////

  always_comb
  begin
    unit_addr = addr_q >> size_q;
    next_unit = unit_addr + 1'b1;
    // Wrapping bursts keep the bits above the wrap boundary
    case (burst_q)
      wrap4:   next_unit = {unit_addr[addr_width-1:2], next_unit[1:0]};
      wrap8:   next_unit = {unit_addr[addr_width-1:3], next_unit[2:0]};
      wrap16:  next_unit = {unit_addr[addr_width-1:4], next_unit[3:0]};
      default: next_unit = next_unit;
    endcase
    expected_addr = next_unit << size_q;
  end

endmodule

/* ahb_bus_if.sv */
////////////////////////////////////////
// AHB3-Lite bus bundle
// Internal bus between the memory slave
// and the protocol monitor
////////////////////////////////////////

interface ahb_bus_if (
  input logic HCLK,
  input logic HRESETn
);
  import ahb3lite_pkg::*;

  // Master side
  logic                  hsel;
  logic [addr_width-1:0] haddr;
  logic [data_width-1:0] hwdata;
  logic                  hwrite;
  hsize_t                hsize;
  hburst_t               hburst;
  htrans_t               htrans;

  // Slave side
  logic [data_width-1:0] hrdata;
  logic                  hready;
  hresp_t                hresp;

  // Slave answers the bus, width and burst type are not needed there
  modport slave (
    input  HCLK, HRESETn, hsel, haddr, hwdata, hwrite, htrans,
    output hrdata, hready, hresp
  );

  // Monitor only observes
  modport monitor (
    input HCLK, HRESETn, hsel, haddr, hwdata, hwrite, hsize, hburst, htrans,
    input hrdata, hready, hresp
  );

endinterface

/* ahb3lite_pkg.sv */
////////////////////////////////////////
// AHB3-Lite shared definitions
// Bus geometry, memory depth and the
// encoded bus fields and violation codes
////////////////////////////////////////

package ahb3lite_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  // HADDR and data bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // Memory depth in words, byte range is four times this
  localparam int mem_words = 256;

  ////////////////////////////////////////
  // Bus fields
  ////////////////////////////////////////

  // Transfer type
  typedef enum logic [1:0] {
    idle   = 2'b00,
    busy   = 2'b01,
    nonseq = 2'b10,
    seq    = 2'b11
  } htrans_t;

  // Burst type
  typedef enum logic [2:0] {
    single = 3'b000,
    incr   = 3'b001,
    wrap4  = 3'b010,
    incr4  = 3'b011,
    wrap8  = 3'b100,
    incr8  = 3'b101,
    wrap16 = 3'b110,
    incr16 = 3'b111
  } hburst_t;

  // Transfer size, bytes = 1 << value
  typedef enum logic [2:0] {
    size_byte  = 3'b000,
    size_hword = 3'b001,
    size_word  = 3'b010,
    size_dword = 3'b011,
    size_b128  = 3'b100,
    size_b256  = 3'b101,
    size_b512  = 3'b110,
    size_b1024 = 3'b111
  } hsize_t;

  // Slave response
  typedef enum logic {
    okay  = 1'b0,
    error = 1'b1
  } hresp_t;

  // Monitor violation codes, lower value wins
  typedef enum logic [3:0] {
    none               = 4'd0,
    seq_outside_burst  = 4'd1,
    busy_outside_burst = 4'd2,
    burst_early_end    = 4'd3,
    unstable_wait      = 4'd4,
    unstable_burst     = 4'd5,
    burst_addr         = 4'd6,
    hsize_range        = 4'd7,
    slave_idle_resp    = 4'd8,
    slave_error_seq    = 4'd9
  } violation_t;

endpackage
